/* tomasulo_pkg.sv */
`default_nettype none

package tomasulo_pkg;

  // width of every data value in the cluster
  localparam int XLEN = 32;

  // rename tags name the producer of a value, 16 of them in flight at most
  localparam int TAG_W = 4;

  localparam int OP_W = 3;  // opcode field width

  // station geometry
  localparam int NUM_STATIONS = 3;
  localparam int STATION_SIZE = 4;
  localparam int SLOT_W = 2;  // indexes one entry inside a station

  // indexes one station, used by the dispatcher and the arbiter pointers
  localparam int STATION_W = $clog2(NUM_STATIONS);

  // single-cycle integer operations
  // shifts take their amount from the low 5 bits of operand 2
  typedef enum logic [OP_W-1:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_SLL = 3'd5,
    OP_SRL = 3'd6
  } op_e;

endpackage

`default_nettype wire

/* reservation_station.sv */
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
  input  logic                             global_bus,
  input  logic                             rst,
  input  logic                             write,
  input  tomasulo_pkg::op_e                issue_op,
  input  logic [tomasulo_pkg::TAG_W-1:0]   issue_dest,
  input  logic [tomasulo_pkg::TAG_W-1:0]   issue_src_1_tag,
  input  logic [tomasulo_pkg::TAG_W-1:0]   issue_src_2_tag,
  input  logic                             issue_src_1_ready,
  input  logic                             issue_src_2_ready,
  input  logic                             issue_spec,
  input  logic [tomasulo_pkg::XLEN-1:0]    issue_src_1_data,
  input  logic [tomasulo_pkg::XLEN-1:0]    issue_src_2_data,
  input  logic                             cdb_valid,
  input  logic [tomasulo_pkg::TAG_W-1:0]   cdb_tag,
  input  logic [tomasulo_pkg::XLEN-1:0]    cdb_result,
  input  logic                             flush,
  input  logic                             grant,
  output logic                             full,
  output logic                             ready_valid,
  output tomasulo_pkg::op_e                ready_op,
  output logic [tomasulo_pkg::XLEN-1:0]    ready_data_1,
  output logic [tomasulo_pkg::XLEN-1:0]    ready_data_2,
  output logic [tomasulo_pkg::TAG_W-1:0]   ready_dest,
  output logic                             ready_spec
);

  // true when a still missing operand is produced by the tag on the bus
  function automatic logic match_cdb(input logic [tomasulo_pkg::TAG_W-1:0] src,
                                     input logic operand_ok, input logic bus_valid,
                                     input logic [tomasulo_pkg::TAG_W-1:0] bus_tag);
    return bus_valid && !operand_ok && (src == bus_tag);
  endfunction

  logic [tomasulo_pkg::STATION_SIZE-1:0] rec_valid;
  tomasulo_pkg::op_e                     rec_op     [tomasulo_pkg::STATION_SIZE];
  logic [tomasulo_pkg::TAG_W-1:0]        rec_tag_1  [tomasulo_pkg::STATION_SIZE];
  logic [tomasulo_pkg::TAG_W-1:0]        rec_tag_2  [tomasulo_pkg::STATION_SIZE];
  logic                                  rec_ok_1   [tomasulo_pkg::STATION_SIZE];
  logic                                  rec_ok_2   [tomasulo_pkg::STATION_SIZE];
  logic [tomasulo_pkg::XLEN-1:0]         rec_data_1 [tomasulo_pkg::STATION_SIZE];
  logic [tomasulo_pkg::XLEN-1:0]         rec_data_2 [tomasulo_pkg::STATION_SIZE];
  logic [tomasulo_pkg::TAG_W-1:0]        rec_dest   [tomasulo_pkg::STATION_SIZE];
  logic                                  rec_spec   [tomasulo_pkg::STATION_SIZE];

  logic [tomasulo_pkg::SLOT_W-1:0] free_slot;
  logic [tomasulo_pkg::SLOT_W-1:0] ready_slot;
  logic                            new_ok_1;
  logic                            new_ok_2;

  assign full = &rec_valid;

  // a source may be broadcast on the very edge the instruction is written
  assign new_ok_1 = issue_src_1_ready ||
                    match_cdb(issue_src_1_tag, issue_src_1_ready, cdb_valid, cdb_tag);
  assign new_ok_2 = issue_src_2_ready ||
                    match_cdb(issue_src_2_tag, issue_src_2_ready, cdb_valid, cdb_tag);

  // scanning downwards leaves the lowest index selected
  always_comb begin : pick_slots
    free_slot   = '0;
    ready_slot  = '0;
    ready_valid = 1'b0;
    for (int j = tomasulo_pkg::STATION_SIZE - 1; j >= 0; j--) begin
      if (!rec_valid[j]) free_slot = tomasulo_pkg::SLOT_W'(j);
      if (rec_valid[j] && rec_ok_1[j] && rec_ok_2[j]) begin
        ready_valid = 1'b1;
        ready_slot  = tomasulo_pkg::SLOT_W'(j);
      end
    end
  end

  assign ready_op     = rec_op[ready_slot];
  assign ready_data_1 = rec_data_1[ready_slot];
  assign ready_data_2 = rec_data_2[ready_slot];
  assign ready_dest   = rec_dest[ready_slot];
  assign ready_spec   = rec_spec[ready_slot];

  always_ff @(posedge global_bus) begin : entry_state
    if (rst) begin
      rec_valid <= '0;
    end else begin
      for (int j = 0; j < tomasulo_pkg::STATION_SIZE; j++) begin
        if (grant && ready_valid && ready_slot == tomasulo_pkg::SLOT_W'(j)) begin
          rec_valid[j] <= 1'b0;  // granted entry leaves for execution
        end
        // a speculative instruction arriving with the flush is dropped at once
        if (write && free_slot == tomasulo_pkg::SLOT_W'(j) && !(flush && issue_spec)) begin
          rec_valid[j] <= 1'b1;
        end
        if (flush && rec_valid[j] && rec_spec[j]) rec_valid[j] <= 1'b0;
      end
    end
  end

  always_ff @(posedge global_bus) begin : entry_payload
    for (int j = 0; j < tomasulo_pkg::STATION_SIZE; j++) begin
      if (write && free_slot == tomasulo_pkg::SLOT_W'(j)) begin
        rec_op[j]     <= issue_op;
        rec_dest[j]   <= issue_dest;
        rec_spec[j]   <= issue_spec;
        rec_tag_1[j]  <= issue_src_1_tag;
        rec_tag_2[j]  <= issue_src_2_tag;
        rec_ok_1[j]   <= new_ok_1;
        rec_ok_2[j]   <= new_ok_2;
        rec_data_1[j] <= issue_src_1_ready ? issue_src_1_data : cdb_result;
        rec_data_2[j] <= issue_src_2_ready ? issue_src_2_data : cdb_result;
      end else begin
        // waiting operands snoop the common data bus
        if (match_cdb(rec_tag_1[j], rec_ok_1[j], cdb_valid, cdb_tag)) begin
          rec_data_1[j] <= cdb_result;
          rec_ok_1[j]   <= 1'b1;
        end
        if (match_cdb(rec_tag_2[j], rec_ok_2[j], cdb_valid, cdb_tag)) begin
          rec_data_2[j] <= cdb_result;
          rec_ok_2[j]   <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* issue_dispatch.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_dispatch (
  input  logic                                  global_bus,
  input  logic                                  rst,
  input  logic                                  issue_valid,
  input  logic [tomasulo_pkg::NUM_STATIONS-1:0] station_full,
  output logic                                  issue_ready,
  output logic [tomasulo_pkg::NUM_STATIONS-1:0] station_write
);

  logic [tomasulo_pkg::STATION_W-1:0] start_ptr;  // first station tried for the next issue
  logic [tomasulo_pkg::STATION_W-1:0] pick;
  logic                               pick_found;

  assign issue_ready = ~&station_full;

  // first station with room at or after the start pointer, wrapping around
  always_comb begin : choose_station
    int idx;
    pick       = '0;
    pick_found = 1'b0;
    for (int k = 0; k < tomasulo_pkg::NUM_STATIONS; k++) begin
      idx = (int'(start_ptr) + k) % tomasulo_pkg::NUM_STATIONS;
      if (!pick_found && !station_full[idx]) begin
        pick       = tomasulo_pkg::STATION_W'(idx);
        pick_found = 1'b1;
      end
    end
  end

  always_comb begin : write_strobe
    station_write = '0;
    if (issue_valid && pick_found) station_write[pick] = 1'b1;
  end

  // moving past the chosen station spreads work over all of them
  always_ff @(posedge global_bus) begin : rotate
    if (rst) begin
      start_ptr <= '0;
    end else if (issue_valid && pick_found) begin
      if (pick == tomasulo_pkg::STATION_W'(tomasulo_pkg::NUM_STATIONS - 1)) start_ptr <= '0;
      else start_ptr <= pick + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* result_broadcast.sv */
`timescale 1ns/1ps
`default_nettype none

module result_broadcast (
  input  logic                                                       global_bus,
  input  logic                                                       rst,
  input  logic                                                       flush,
  input  logic [tomasulo_pkg::NUM_STATIONS-1:0]                      ready_valid,
  input  logic [tomasulo_pkg::NUM_STATIONS-1:0][tomasulo_pkg::OP_W-1:0]  ready_op,
  input  logic [tomasulo_pkg::NUM_STATIONS-1:0][tomasulo_pkg::XLEN-1:0]  ready_data_1,
  input  logic [tomasulo_pkg::NUM_STATIONS-1:0][tomasulo_pkg::XLEN-1:0]  ready_data_2,
  input  logic [tomasulo_pkg::NUM_STATIONS-1:0][tomasulo_pkg::TAG_W-1:0] ready_dest,
  input  logic [tomasulo_pkg::NUM_STATIONS-1:0]                      ready_spec,
  output logic [tomasulo_pkg::NUM_STATIONS-1:0]                      grant,
  output logic                                                       cdb_valid,
  output logic [tomasulo_pkg::TAG_W-1:0]                             cdb_tag,
  output logic [tomasulo_pkg::XLEN-1:0]                              cdb_result
);

  logic [tomasulo_pkg::STATION_W-1:0]    rr_ptr;  // station after the last winner
  logic [tomasulo_pkg::NUM_STATIONS-1:0] next_grant;
  logic [tomasulo_pkg::STATION_W-1:0]    winner;
  logic                                  win_found;

  logic                           sel_valid;
  tomasulo_pkg::op_e              sel_op;
  logic [tomasulo_pkg::XLEN-1:0]  sel_a;
  logic [tomasulo_pkg::XLEN-1:0]  sel_b;
  logic [tomasulo_pkg::TAG_W-1:0] sel_dest;
  logic                           sel_spec;
  logic [tomasulo_pkg::XLEN-1:0]  alu_result;

  // a station granted now still shows the leaving entry, so it sits this round out
  always_comb begin : arbitrate
    int idx;
    next_grant = '0;
    winner     = '0;
    win_found  = 1'b0;
    for (int k = 0; k < tomasulo_pkg::NUM_STATIONS; k++) begin
      idx = (int'(rr_ptr) + k) % tomasulo_pkg::NUM_STATIONS;
      if (!win_found && ready_valid[idx] && !grant[idx]) begin
        winner          = tomasulo_pkg::STATION_W'(idx);
        win_found       = 1'b1;
        next_grant[idx] = 1'b1;
      end
    end
  end

  always_ff @(posedge global_bus) begin : grant_reg
    if (rst) begin
      grant  <= '0;
      rr_ptr <= '0;
    end else begin
      grant <= next_grant;
      if (win_found) begin
        if (winner == tomasulo_pkg::STATION_W'(tomasulo_pkg::NUM_STATIONS - 1)) rr_ptr <= '0;
        else rr_ptr <= winner + 1'b1;
      end
    end
  end

  // the station may have lost its entry to a flush, hence the ready_valid check
  always_comb begin : select_granted
    sel_valid = 1'b0;
    sel_op    = tomasulo_pkg::OP_ADD;
    sel_a     = '0;
    sel_b     = '0;
    sel_dest  = '0;
    sel_spec  = 1'b0;
    for (int s = 0; s < tomasulo_pkg::NUM_STATIONS; s++) begin
      if (grant[s] && ready_valid[s]) begin
        sel_valid = 1'b1;
        sel_op    = tomasulo_pkg::op_e'(ready_op[s]);
        sel_a     = ready_data_1[s];
        sel_b     = ready_data_2[s];
        sel_dest  = ready_dest[s];
        sel_spec  = ready_spec[s];
      end
    end
  end

  always_comb begin : alu
    case (sel_op)
      tomasulo_pkg::OP_ADD: alu_result = sel_a + sel_b;
      tomasulo_pkg::OP_SUB: alu_result = sel_a - sel_b;
      tomasulo_pkg::OP_AND: alu_result = sel_a & sel_b;
      tomasulo_pkg::OP_OR:  alu_result = sel_a | sel_b;
      tomasulo_pkg::OP_XOR: alu_result = sel_a ^ sel_b;
      tomasulo_pkg::OP_SLL: alu_result = sel_a << sel_b[4:0];
      tomasulo_pkg::OP_SRL: alu_result = sel_a >> sel_b[4:0];
      default:              alu_result = '0;
    endcase
  end

  always_ff @(posedge global_bus) begin : cdb_ctrl
    if (rst) cdb_valid <= 1'b0;
    else cdb_valid <= sel_valid && !(sel_spec && flush);  // flushed results never appear
  end

  always_ff @(posedge global_bus) begin : cdb_payload
    cdb_tag    <= sel_dest;
    cdb_result <= alu_result;
  end

endmodule

`default_nettype wire

/* exec_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module exec_cluster (
  input  logic                           global_bus,
  input  logic                           rst,
  input  logic                           issue_valid,
  output logic                           issue_ready,
  input  tomasulo_pkg::op_e              issue_op,
  input  logic [tomasulo_pkg::TAG_W-1:0] issue_dest,
  input  logic                           issue_spec,
  input  logic [tomasulo_pkg::TAG_W-1:0] issue_src_1_tag,
  input  logic                           issue_src_1_ready,
  input  logic [tomasulo_pkg::XLEN-1:0]  issue_src_1_data,
  input  logic [tomasulo_pkg::TAG_W-1:0] issue_src_2_tag,
  input  logic                           issue_src_2_ready,
  input  logic [tomasulo_pkg::XLEN-1:0]  issue_src_2_data,
  input  logic                           flush,
  output logic                           cdb_valid,
  output logic [tomasulo_pkg::TAG_W-1:0] cdb_tag,
  output logic [tomasulo_pkg::XLEN-1:0]  cdb_result
);

  logic [tomasulo_pkg::NUM_STATIONS-1:0] station_full;
  logic [tomasulo_pkg::NUM_STATIONS-1:0] station_write;
  logic [tomasulo_pkg::NUM_STATIONS-1:0] grant;

  // per-station offers, packed so the broadcast unit can index them
  logic [tomasulo_pkg::NUM_STATIONS-1:0]                         ready_valid;
  logic [tomasulo_pkg::NUM_STATIONS-1:0][tomasulo_pkg::OP_W-1:0]  ready_op;
  logic [tomasulo_pkg::NUM_STATIONS-1:0][tomasulo_pkg::XLEN-1:0]  ready_data_1;
  logic [tomasulo_pkg::NUM_STATIONS-1:0][tomasulo_pkg::XLEN-1:0]  ready_data_2;
  logic [tomasulo_pkg::NUM_STATIONS-1:0][tomasulo_pkg::TAG_W-1:0] ready_dest;
  logic [tomasulo_pkg::NUM_STATIONS-1:0]                         ready_spec;

  issue_dispatch i_dispatch (
    .global_bus    (global_bus),
    .rst           (rst),
    .issue_valid   (issue_valid),
    .station_full  (station_full),
    .issue_ready   (issue_ready),
    .station_write (station_write)
  );

  // every station sees the same issue fields, only its write strobe differs
  for (genvar i = 0; i < tomasulo_pkg::NUM_STATIONS; i++) begin : gen_station
    reservation_station i_station (
      .global_bus (global_bus), .rst (rst), .write (station_write[i]),
      .issue_op (issue_op), .issue_dest (issue_dest), .issue_spec (issue_spec),
      .issue_src_1_tag (issue_src_1_tag), .issue_src_2_tag (issue_src_2_tag),
      .issue_src_1_ready (issue_src_1_ready), .issue_src_2_ready (issue_src_2_ready),
      .issue_src_1_data (issue_src_1_data), .issue_src_2_data (issue_src_2_data),
      .cdb_valid (cdb_valid), .cdb_tag (cdb_tag), .cdb_result (cdb_result),
      .flush (flush), .grant (grant[i]), .full (station_full[i]),
      .ready_valid (ready_valid[i]), .ready_op (ready_op[i]),
      .ready_data_1 (ready_data_1[i]), .ready_data_2 (ready_data_2[i]),
      .ready_dest (ready_dest[i]), .ready_spec (ready_spec[i])
    );
  end

  result_broadcast i_broadcast (
    .global_bus   (global_bus),
    .rst          (rst),
    .flush        (flush),
    .ready_valid  (ready_valid),
    .ready_op     (ready_op),
    .ready_data_1 (ready_data_1),
    .ready_data_2 (ready_data_2),
    .ready_dest   (ready_dest),
    .ready_spec   (ready_spec),
    .grant        (grant),
    .cdb_valid    (cdb_valid),
    .cdb_tag      (cdb_tag),
    .cdb_result   (cdb_result)
  );

endmodule

`default_nettype wire

/* tb_result_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_result_checker (
  input logic                           global_bus,
  input logic                           rst,
  input logic                           issue_valid,
  input logic                           issue_ready,
  input tomasulo_pkg::op_e              issue_op,
  input logic [tomasulo_pkg::TAG_W-1:0] issue_dest,
  input logic                           issue_spec,
  input logic [tomasulo_pkg::TAG_W-1:0] issue_src_1_tag,
  input logic                           issue_src_1_ready,
  input logic [tomasulo_pkg::XLEN-1:0]  issue_src_1_data,
  input logic [tomasulo_pkg::TAG_W-1:0] issue_src_2_tag,
  input logic                           issue_src_2_ready,
  input logic [tomasulo_pkg::XLEN-1:0]  issue_src_2_data,
  input logic                           flush,
  input logic                           cdb_valid,
  input logic [tomasulo_pkg::TAG_W-1:0] cdb_tag,
  input logic [tomasulo_pkg::XLEN-1:0]  cdb_result
);

  localparam int NTAGS = 1 << tomasulo_pkg::TAG_W;

  string test_name = "none";  // set by the testbench top for error lines
  int    error_count = 0;
  int    unexpected_count = 0;
  int    outstanding = 0;
  int    done_count = 0;

  // model of every instruction in flight, indexed by its destination tag
  logic                          pending [NTAGS] = '{default: 1'b0};
  tomasulo_pkg::op_e             m_op    [NTAGS];
  logic                          m_spec  [NTAGS];
  logic                          m_have_1 [NTAGS];
  logic                          m_have_2 [NTAGS];
  logic [tomasulo_pkg::TAG_W-1:0] m_tag_1 [NTAGS];
  logic [tomasulo_pkg::TAG_W-1:0] m_tag_2 [NTAGS];
  logic [tomasulo_pkg::XLEN-1:0]  m_val_1 [NTAGS];
  logic [tomasulo_pkg::XLEN-1:0]  m_val_2 [NTAGS];

  function automatic logic [31:0] model_result(input tomasulo_pkg::op_e op,
                                               input logic [31:0] a, input logic [31:0] b);
    case (op)
      tomasulo_pkg::OP_ADD: return a + b;
      tomasulo_pkg::OP_SUB: return a - b;
      tomasulo_pkg::OP_AND: return a & b;
      tomasulo_pkg::OP_OR:  return a | b;
      tomasulo_pkg::OP_XOR: return a ^ b;
      tomasulo_pkg::OP_SLL: return a << b[4:0];
      tomasulo_pkg::OP_SRL: return a >> b[4:0];
      default:              return 32'h0;
    endcase
  endfunction

  // everything seen here is what the next rising edge acts on
  always @(negedge global_bus) begin : watch
    logic [31:0] want;
    if (rst) begin
      for (int t = 0; t < NTAGS; t++) pending[t] = 1'b0;
      outstanding = 0;
    end else begin
      if (cdb_valid) begin
        if (!pending[cdb_tag]) begin
          $display("Unexpected broadcast in %s: tag %0d has no outstanding instruction",
                   test_name, cdb_tag);
          error_count++;
          unexpected_count++;
        end else if (!(m_have_1[cdb_tag] && m_have_2[cdb_tag])) begin
          $display("Tag %0d in %s was broadcast before its operands were produced",
                   cdb_tag, test_name);
          error_count++;
        end else begin
          want = model_result(m_op[cdb_tag], m_val_1[cdb_tag], m_val_2[cdb_tag]);
          if (want !== cdb_result) begin
            $display("Mismatch in %s: tag %0d expected %h actual %h",
                     test_name, cdb_tag, want, cdb_result);
            error_count++;
          end
        end
        if (pending[cdb_tag]) begin
          pending[cdb_tag] = 1'b0;
          outstanding--;
          done_count++;
        end
        for (int t = 0; t < NTAGS; t++) begin  // wake up the consumers
          if (pending[t] && !m_have_1[t] && m_tag_1[t] == cdb_tag) begin
            m_val_1[t]  = cdb_result;
            m_have_1[t] = 1'b1;
          end
          if (pending[t] && !m_have_2[t] && m_tag_2[t] == cdb_tag) begin
            m_val_2[t]  = cdb_result;
            m_have_2[t] = 1'b1;
          end
        end
      end
      if (flush) begin
        for (int t = 0; t < NTAGS; t++) begin
          if (pending[t] && m_spec[t]) begin
            pending[t] = 1'b0;
            outstanding--;
          end
        end
      end
      if (issue_valid && issue_ready && !(flush && issue_spec)) begin
        pending[issue_dest] = 1'b1;
        outstanding++;
        m_op[issue_dest]     = issue_op;
        m_spec[issue_dest]   = issue_spec;
        m_tag_1[issue_dest]  = issue_src_1_tag;
        m_tag_2[issue_dest]  = issue_src_2_tag;
        // a producer on the bus right now hands its value over at once
        m_have_1[issue_dest] = issue_src_1_ready || (cdb_valid && cdb_tag == issue_src_1_tag);
        m_have_2[issue_dest] = issue_src_2_ready || (cdb_valid && cdb_tag == issue_src_2_tag);
        m_val_1[issue_dest]  = issue_src_1_ready ? issue_src_1_data : cdb_result;
        m_val_2[issue_dest]  = issue_src_2_ready ? issue_src_2_data : cdb_result;
      end
    end
  end

endmodule

`default_nettype wire

/* tb_exec_cluster.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_exec_cluster;

  localparam int NTAGS = 1 << tomasulo_pkg::TAG_W;
  localparam int TIMEOUT = 500;
  localparam int CAPACITY = tomasulo_pkg::NUM_STATIONS * tomasulo_pkg::STATION_SIZE;

  logic                           global_bus = 1'b0;
  logic                           rst = 1'b1;
  logic                           issue_valid = 1'b0;
  logic                           issue_ready;
  tomasulo_pkg::op_e              issue_op = tomasulo_pkg::OP_ADD;
  logic [tomasulo_pkg::TAG_W-1:0] issue_dest = '0;
  logic                           issue_spec = 1'b0;
  logic [tomasulo_pkg::TAG_W-1:0] issue_src_1_tag = '0;
  logic                           issue_src_1_ready = 1'b1;
  logic [tomasulo_pkg::XLEN-1:0]  issue_src_1_data = '0;
  logic [tomasulo_pkg::TAG_W-1:0] issue_src_2_tag = '0;
  logic                           issue_src_2_ready = 1'b1;
  logic [tomasulo_pkg::XLEN-1:0]  issue_src_2_data = '0;
  logic                           flush = 1'b0;
  logic                           cdb_valid;
  logic [tomasulo_pkg::TAG_W-1:0] cdb_tag;
  logic [tomasulo_pkg::XLEN-1:0]  cdb_result;

  logic [31:0] lfsr = 32'hb528;
  logic        busy     [NTAGS] = '{default: 1'b0};  // tag owned by an instruction in flight
  logic        tag_spec [NTAGS] = '{default: 1'b0};
  int          tb_errors = 0;
  int          start_errors = 0;
  logic        timed_out = 1'b0;
  int          hold_tag;

  always #5 global_bus = ~global_bus;

  exec_cluster i_dut (.*);

  tb_result_checker i_check (.*);

  // tags come free once their result is on the bus or a flush removed them
  always @(negedge global_bus) begin : track_tags
    if (cdb_valid) busy[cdb_tag] = 1'b0;
    if (flush) begin
      for (int t = 0; t < NTAGS; t++) if (tag_spec[t]) busy[t] = 1'b0;
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic report_timeout(input string what);
    $display("Timeout in %s: %s", i_check.test_name, what);
    timed_out = 1'b1;
  endtask

  task automatic alloc_tag(input logic spec, output int tag);
    int   n;
    int   start;
    logic found;
    n = 0;
    found = 1'b0;
    tag = 0;
    while (!found && !timed_out) begin
      start = int'(rand_bits(4));
      for (int k = 0; k < NTAGS; k++) begin
        if (!found && !busy[(start + k) % NTAGS]) begin
          tag = (start + k) % NTAGS;
          found = 1'b1;
        end
      end
      if (!found) begin
        @(posedge global_bus);
        #1;
        n++;
        if (n > TIMEOUT) report_timeout("no rename tag became free");
      end
    end
    busy[tag] = 1'b1;
    tag_spec[tag] = spec;
  endtask

  // a busy tag is still in flight, or is on the bus in this very cycle
  task automatic pick_source(input logic spec_ok, input int dep_pct, input int self_tag,
                             output logic ready, output int tag);
    int start;
    int cand;
    ready = 1'b1;
    tag = 0;
    if (int'(rand_bits(7)) % 100 < dep_pct) begin
      start = int'(rand_bits(4));
      for (int k = 0; k < NTAGS; k++) begin
        cand = (start + k) % NTAGS;
        // the new instruction's own tag is busy too, but it can never feed itself
        if (ready && busy[cand] && cand != self_tag && (spec_ok || !tag_spec[cand])) begin
          tag = cand;
          ready = 1'b0;
        end
      end
    end
  endtask

  task automatic issue_instr(input logic spec, input int dep_pct,
                             input int dep_tag, input int fixed_dest);
    int   dest;
    int   t1;
    int   t2;
    logic r1;
    logic r2;
    int   n;
    n = 0;
    if (fixed_dest >= 0) dest = fixed_dest;
    else alloc_tag(spec, dest);
    while (!issue_ready && !timed_out) begin
      @(posedge global_bus);
      #1;
      n++;
      if (n > TIMEOUT) report_timeout("issue_ready stayed low");
    end
    if (timed_out) return;
    pick_source(spec, dep_pct, dest, r1, t1);
    pick_source(spec, dep_pct, dest, r2, t2);
    if (dep_tag >= 0) begin
      r1 = 1'b0;
      t1 = dep_tag;
    end
    issue_op          = tomasulo_pkg::op_e'(3'(rand_bits(3) % 7));
    issue_dest        = tomasulo_pkg::TAG_W'(dest);
    issue_spec        = spec;
    issue_src_1_tag   = tomasulo_pkg::TAG_W'(t1);
    issue_src_1_ready = r1;
    issue_src_1_data  = rand_bits(32);
    issue_src_2_tag   = tomasulo_pkg::TAG_W'(t2);
    issue_src_2_ready = r2;
    issue_src_2_data  = rand_bits(32);
    issue_valid       = 1'b1;
    @(posedge global_bus);
    #1;
    issue_valid = 1'b0;
  endtask

  task automatic drain();
    int n;
    n = 0;
    while (i_check.outstanding != 0 && !timed_out) begin
      @(posedge global_bus);
      #1;
      n++;
      if (n > TIMEOUT) report_timeout("instructions never completed");
    end
  endtask

  task automatic pulse_flush();
    flush = 1'b1;
    @(posedge global_bus);
    #1;
    flush = 1'b0;
  endtask

  task automatic begin_test(input string name);
    i_check.test_name = name;
    start_errors = i_check.error_count + tb_errors;
  endtask

  task automatic end_test();
    $display("test %s finished with %0d errors", i_check.test_name,
             i_check.error_count + tb_errors - start_errors);
  endtask

  initial begin
    repeat (3) @(posedge global_bus);
    #1;
    rst = 1'b0;

    begin_test("reset");
    if (cdb_valid !== 1'b0 || issue_ready !== 1'b1) begin
      $display("After reset cdb_valid is not low or issue_ready is not high");
      tb_errors++;
    end
    end_test();

    begin_test("independent");
    for (int i = 0; i < 40; i++) issue_instr(1'b0, 0, -1, -1);
    drain();
    end_test();

    begin_test("chains");
    for (int i = 0; i < 40; i++) issue_instr(1'b0, 60, -1, -1);
    drain();
    end_test();

    // every slot waits on the held tag, so a flush of the speculative half makes room
    // for its producer
    begin_test("backpressure");
    alloc_tag(1'b0, hold_tag);
    for (int i = 0; i < CAPACITY; i++) issue_instr(1'(i % 2), 0, hold_tag, -1);
    repeat (3) begin
      @(posedge global_bus);
      #1;
      if (issue_ready !== 1'b0) begin
        $display("issue_ready is high although every station is full");
        tb_errors++;
      end
    end
    pulse_flush();
    issue_instr(1'b0, 0, -1, hold_tag);
    drain();
    if (issue_ready !== 1'b1) begin
      $display("issue_ready did not return high after the stations drained");
      tb_errors++;
    end
    end_test();

    begin_test("flush");
    for (int i = 0; i < 24; i++) begin
      if (i == 14) pulse_flush();
      issue_instr(rand_bits(1) == 32'h1, 50, -1, -1);
    end
    pulse_flush();
    drain();
    end_test();

    begin_test("stray_broadcast");
    repeat (20) @(posedge global_bus);
    #1;
    if (i_check.unexpected_count != 0) begin
      $display("%0d broadcasts had no outstanding instruction", i_check.unexpected_count);
    end
    end_test();

    $display("%0d results checked, %0d errors", i_check.done_count,
             i_check.error_count + tb_errors);
    if (i_check.error_count + tb_errors == 0 && !timed_out) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim.f */
tomasulo_pkg.sv
reservation_station.sv
issue_dispatch.sv
result_broadcast.sv
exec_cluster.sv
tb_result_checker.sv
tb_exec_cluster.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing -f sim.f --top-module tb_exec_cluster -Mdir obj_dir -o sim_exec
	./obj_dir/sim_exec | tee sim.log
	grep -q "RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log
